// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= tb_vdp_command
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "Result: PASSED" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== hdl/vdp_cmd_pkg.sv ====
`default_nettype none

package vdp_cmd_pkg;

  // Coordinate and address widths
  localparam int COORD_X_W   = 10;  // DX, NX
  localparam int COORD_Y_W   = 10;  // DY, NY
  localparam int VRAM_ADDR_W = 17;  // 128 KiB of VRAM
  localparam int REG_NUM_W   = 4;   // Offset from R32

  // Command codes in CMR bits 7..4
  localparam logic [3:0] CMD_HMMV = 4'b1100;  // Byte fill
  localparam logic [3:0] CMD_LMMV = 4'b1000;  // Logical pixel fill
  localparam logic [3:0] CMD_PSET = 4'b0101;  // Single pixel

  // Logic ops in CMR bits 2..0
  // Other codes keep the destination
  localparam logic [2:0] LOP_IMP = 3'b000;
  localparam logic [2:0] LOP_AND = 3'b001;
  localparam logic [2:0] LOP_OR  = 3'b010;
  localparam logic [2:0] LOP_XOR = 3'b011;
  localparam logic [2:0] LOP_NOT = 3'b100;

  // Register offsets for R36..R46
  localparam logic [3:0] REG_DX_L = 4'd4;
  localparam logic [3:0] REG_DX_H = 4'd5;
  localparam logic [3:0] REG_DY_L = 4'd6;
  localparam logic [3:0] REG_DY_H = 4'd7;
  localparam logic [3:0] REG_NX_L = 4'd8;
  localparam logic [3:0] REG_NX_H = 4'd9;
  localparam logic [3:0] REG_NY_L = 4'd10;
  localparam logic [3:0] REG_NY_H = 4'd11;
  localparam logic [3:0] REG_CLR  = 4'd12;
  localparam logic [3:0] REG_ARG  = 4'd13;
  localparam logic [3:0] REG_CMR  = 4'd14;

  // Pixel operation word with addr on top and the byte flag at bit 0
  localparam int PIXOP_W        = 31;
  localparam int PIXOP_BYTE_BIT = 0;
  localparam int PIXOP_LOP_LSB  = 1;   // 4 bits with T on top
  localparam int PIXOP_CLR_LSB  = 5;   // 8 bits
  localparam int PIXOP_XLO_BIT  = 13;
  localparam int PIXOP_ADDR_LSB = 14;  // VRAM_ADDR_W bits

  // RMW unit states
  localparam logic [1:0] RMW_IDLE    = 2'd0;
  localparam logic [1:0] RMW_WAIT_RD = 2'd1;
  localparam logic [1:0] RMW_WAIT_WR = 2'd2;

  // One VRAM byte holds a graphic 7 pixel or two graphic 4 pixels
  typedef union packed {
    logic [7:0] pix8;
    struct packed {
      logic [3:0] pix_hi;  // Even X
      logic [3:0] pix_lo;  // Odd X
    } nib;
  } vram_byte_u;

endpackage

`default_nettype wire

// ==== hdl/vdp_cmd_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module vdp_cmd_regs (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                reg_wr_req,
  input  logic [vdp_cmd_pkg::REG_NUM_W-1:0]   reg_num,
  input  logic [7:0]                          reg_data,
  input  logic                                mode_graphic_7,
  input  logic                                walk_done,
  input  logic                                fifo_empty,
  input  logic                                rmw_idle,
  output logic                                reg_wr_ack,
  output logic                                start,
  output logic [vdp_cmd_pkg::COORD_X_W-1:0]   dx,
  output logic [vdp_cmd_pkg::COORD_Y_W-1:0]   dy,
  output logic [vdp_cmd_pkg::COORD_X_W-1:0]   nx,
  output logic [vdp_cmd_pkg::COORD_Y_W-1:0]   ny,
  output logic [7:0]                          clr,
  output logic                                dix,
  output logic                                diy,
  output logic [3:0]                          cmd,
  output logic [3:0]                          logic_op,
  output logic                                ce
);
  import vdp_cmd_pkg::*;

  logic [3:0] new_cmd;    // Code being written to R46
  logic       cmd_known;
  logic       pixel_cmd;  // LMMV or PSET
  logic       done;

  assign new_cmd   = reg_data[7:4];
  assign cmd_known = (new_cmd == CMD_HMMV) || (new_cmd == CMD_LMMV) || (new_cmd == CMD_PSET);
  assign pixel_cmd = (new_cmd == CMD_LMMV) || (new_cmd == CMD_PSET);
  // Walker is still done in the start cycle, so start blocks completion
  assign done = ce && !start && walk_done && fifo_empty && rmw_idle;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      reg_wr_ack <= 1'b0;
      start      <= 1'b0;
      ce         <= 1'b0;
      dx         <= '0;
      dy         <= '0;
      nx         <= '0;
      ny         <= '0;
      clr        <= '0;
      dix        <= 1'b0;
      diy        <= 1'b0;
      cmd        <= '0;
      logic_op   <= '0;
    end else begin
      start <= 1'b0;  // One-cycle pulse
      if (done) begin
        ce <= 1'b0;
      end
      if (reg_wr_req != reg_wr_ack) begin  // Pending CPU write
        reg_wr_ack <= ~reg_wr_ack;
        case (reg_num)
          REG_DX_L: dx[7:0] <= reg_data;
          REG_DX_H: dx[COORD_X_W-1:8] <= reg_data[COORD_X_W-9:0];
          REG_DY_L: dy[7:0] <= reg_data;
          REG_DY_H: dy[COORD_Y_W-1:8] <= reg_data[COORD_Y_W-9:0];
          REG_NX_L: nx[7:0] <= reg_data;
          REG_NX_H: nx[COORD_X_W-1:8] <= reg_data[COORD_X_W-9:0];
          REG_NY_L: ny[7:0] <= reg_data;
          REG_NY_H: ny[COORD_Y_W-1:8] <= reg_data[COORD_Y_W-9:0];
          REG_CLR:  clr <= reg_data;
          REG_ARG: begin
            dix <= reg_data[2];
            diy <= reg_data[3];
          end
          REG_CMR: begin
            cmd      <= new_cmd;
            logic_op <= reg_data[3:0];
            if (!ce && cmd_known) begin  // No abort while running
              start <= 1'b1;
              ce    <= 1'b1;
              if (pixel_cmd && !mode_graphic_7) begin
                clr <= {4'h0, clr[3:0]};  // 4-bit pixel colour
              end
            end
          end
          default: ;  // SX/SY and R47 not kept
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/vdp_command.sv ====
`timescale 1ns/1ps
`default_nettype none

module vdp_command #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                mode_graphic_7,  // Else graphic 4
  input  logic                                reg_wr_req,
  input  logic [vdp_cmd_pkg::REG_NUM_W-1:0]   reg_num,
  input  logic [7:0]                          reg_data,
  output logic                                reg_wr_ack,
  input  logic                                vram_rd_ack,
  input  logic                                vram_wr_ack,
  input  logic [7:0]                          vram_rd_data,
  output logic                                vram_rd_req,
  output logic                                vram_wr_req,
  output logic [vdp_cmd_pkg::VRAM_ADDR_W-1:0] vram_addr,
  output logic [7:0]                          vram_wr_data,
  output logic                                ce
);
  import vdp_cmd_pkg::*;

  // Regs to walker
  logic                 start;
  logic [COORD_X_W-1:0] dx;
  logic [COORD_Y_W-1:0] dy;
  logic [COORD_X_W-1:0] nx;
  logic [COORD_Y_W-1:0] ny;
  logic [7:0]           clr;
  logic                 dix;
  logic                 diy;
  logic [3:0]           cmd;
  logic [3:0]           logic_op;

  // Pipeline
  logic                 push;
  logic [PIXOP_W-1:0]   push_data;
  logic                 full;
  logic                 empty;
  logic                 pop;
  logic [PIXOP_W-1:0]   pop_data;
  logic                 walk_done;
  logic                 rmw_idle;

  vdp_cmd_regs u_regs (
    .clk, .reset, .reg_wr_req, .reg_num, .reg_data, .mode_graphic_7,
    .walk_done, .fifo_empty(empty), .rmw_idle, .reg_wr_ack, .start,
    .dx, .dy, .nx, .ny, .clr, .dix, .diy, .cmd, .logic_op, .ce
  );

  vdp_rect_walker u_walker (
    .clk, .reset, .start, .dx, .dy, .nx, .ny, .clr, .dix, .diy, .cmd,
    .logic_op, .mode_graphic_7, .full, .push, .push_data, .walk_done
  );

  vdp_pixel_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
    .clk, .reset, .push, .push_data, .pop, .pop_data, .full, .empty
  );

  vdp_vram_rmw u_rmw (
    .clk, .reset, .empty, .pop_data, .mode_graphic_7, .vram_rd_ack,
    .vram_wr_ack, .vram_rd_data, .pop, .vram_rd_req, .vram_wr_req,
    .vram_addr, .vram_wr_data, .rmw_idle
  );

endmodule

`default_nettype wire

// ==== hdl/vdp_pixel_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module vdp_pixel_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              push,
  input  logic [vdp_cmd_pkg::PIXOP_W-1:0]   push_data,
  input  logic                              pop,
  output logic [vdp_cmd_pkg::PIXOP_W-1:0]   pop_data,
  output logic                              full,
  output logic                              empty
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  logic [vdp_cmd_pkg::PIXOP_W-1:0] mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;    // Occupancy
  logic             do_push;
  logic             do_pop;

  assign do_push  = push && !full;
  assign do_pop   = pop && !empty;
  assign full     = (count == CNT_W'(FIFO_DEPTH));
  assign empty    = (count == '0);
  assign pop_data = mem[rd_ptr];  // Head shows without a read cycle

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (do_push != do_pop) begin
        count <= do_push ? count + 1'b1 : count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/vdp_rect_walker.sv ====
`timescale 1ns/1ps
`default_nettype none

module vdp_rect_walker (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                start,
  input  logic [vdp_cmd_pkg::COORD_X_W-1:0]   dx,
  input  logic [vdp_cmd_pkg::COORD_Y_W-1:0]   dy,
  input  logic [vdp_cmd_pkg::COORD_X_W-1:0]   nx,
  input  logic [vdp_cmd_pkg::COORD_Y_W-1:0]   ny,
  input  logic [7:0]                          clr,
  input  logic                                dix,
  input  logic                                diy,
  input  logic [3:0]                          cmd,
  input  logic [3:0]                          logic_op,
  input  logic                                mode_graphic_7,
  input  logic                                full,
  output logic                                push,
  output logic [vdp_cmd_pkg::PIXOP_W-1:0]     push_data,
  output logic                                walk_done
);
  import vdp_cmd_pkg::*;

  logic                   busy;
  logic [COORD_X_W-1:0]   cur_x;
  logic [COORD_Y_W-1:0]   cur_y;
  logic [COORD_X_W-1:0]   rem_x;    // Pixels left in row
  logic [COORD_Y_W-1:0]   rem_y;    // Rows left
  logic [COORD_X_W-1:0]   row_x;    // X at row start
  logic [COORD_X_W-1:0]   row_nx;   // rem_x reload
  logic [3:0]             cmd_q;
  logic [7:0]             clr_q;
  logic [3:0]             lop_q;
  logic                   dix_q;
  logic                   diy_q;

  logic [COORD_X_W-1:0]   nx_eff;
  logic                   byte_g4;
  logic [COORD_X_W-1:0]   x_step;
  logic [COORD_X_W-1:0]   next_x;
  logic [COORD_X_W-1:0]   rem_x_next;
  logic                   row_end;
  logic                   last_row;
  logic [VRAM_ADDR_W-1:0] addr;
  vram_byte_u             colour;

  // HMMV in graphic 4 moves a byte, i.e. two pixels, per step
  assign nx_eff = ((cmd == CMD_HMMV) && !mode_graphic_7) ? {1'b0, nx[COORD_X_W-1:1]} : nx;
  assign byte_g4    = (cmd_q == CMD_HMMV) && !mode_graphic_7;
  assign x_step     = byte_g4 ? COORD_X_W'(2) : COORD_X_W'(1);
  assign next_x     = dix_q ? cur_x - x_step : cur_x + x_step;
  assign rem_x_next = rem_x - COORD_X_W'(1);

  // Count exhausted or X wrapped out of 0..255
  assign row_end  = (cmd_q == CMD_PSET) || (rem_x_next == '0) ||
                    (next_x[COORD_X_W-1:8] != '0);
  assign last_row = (cmd_q == CMD_PSET) || (rem_y == COORD_Y_W'(1)) ||
                    (diy_q && (cur_y == '0));

  always_comb begin
    if (mode_graphic_7) begin
      addr = {cur_y[8:0], cur_x[7:0]};  // One pixel per byte
    end else begin
      addr = {cur_y[9:0], cur_x[7:1]};  // Two pixels per byte
    end
  end

  always_comb begin
    colour.pix8 = clr_q;
    if (!mode_graphic_7 && (cmd_q != CMD_HMMV)) begin
      colour.nib.pix_hi = 4'h0;  // Pixel colour sits in low nibble
    end
  end

  assign push      = busy && !full;  // Hold position under back-pressure
  assign walk_done = !busy;
  assign push_data = {addr, cur_x[0], colour.pix8, lop_q, cmd_q == CMD_HMMV};

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      busy  <= 1'b0;
      cur_x <= '0;
      cur_y <= '0;
      rem_x <= '0;
      rem_y <= '0;
    end else if (start) begin
      busy  <= 1'b1;
      cur_x <= dx;
      cur_y <= dy;
      rem_x <= nx_eff;
      rem_y <= ny;
    end else if (push) begin
      if (!row_end) begin
        cur_x <= next_x;
        rem_x <= rem_x_next;
      end else if (last_row) begin
        busy <= 1'b0;  // Last operation pushed
      end else begin
        cur_x <= row_x;  // Next row
        rem_x <= row_nx;
        rem_y <= rem_y - COORD_Y_W'(1);
        cur_y <= diy_q ? cur_y - COORD_Y_W'(1) : cur_y + COORD_Y_W'(1);
      end
    end
  end

  // Snapshot of the command since registers may change while running
  always_ff @(posedge clk) begin
    if (start) begin
      row_x  <= dx;
      row_nx <= nx_eff;
      cmd_q  <= cmd;
      clr_q  <= clr;
      lop_q  <= logic_op;
      dix_q  <= dix;
      diy_q  <= diy;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/vdp_vram_rmw.sv ====
`timescale 1ns/1ps
`default_nettype none

module vdp_vram_rmw (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                empty,
  input  logic [vdp_cmd_pkg::PIXOP_W-1:0]     pop_data,
  input  logic                                mode_graphic_7,
  input  logic                                vram_rd_ack,
  input  logic                                vram_wr_ack,
  input  logic [7:0]                          vram_rd_data,
  output logic                                pop,
  output logic                                vram_rd_req,
  output logic                                vram_wr_req,
  output logic [vdp_cmd_pkg::VRAM_ADDR_W-1:0] vram_addr,
  output logic [7:0]                          vram_wr_data,
  output logic                                rmw_idle
);
  import vdp_cmd_pkg::*;

  logic [1:0] state;
  logic       x_lo_q;     // Odd X selects the low nibble in graphic 4
  logic [7:0] clr_q;
  logic [2:0] lop_q;

  logic       in_byte;    // HMMV item needs no read
  logic       in_t;
  vram_byte_u in_clr;
  logic       in_skip;    // Transparent colour 0
  vram_byte_u rd_byte;
  logic [7:0] dst_pix;
  logic [7:0] lop_res;
  vram_byte_u merged;
  logic       rd_done;
  logic       wr_done;

  assign in_byte = pop_data[PIXOP_BYTE_BIT];
  assign in_t    = pop_data[PIXOP_LOP_LSB + 3];
  assign in_clr  = pop_data[PIXOP_CLR_LSB +: 8];
  assign in_skip = !in_byte && in_t &&
                   (mode_graphic_7 ? (in_clr.pix8 == 8'h00) : (in_clr.nib.pix_lo == 4'h0));

  assign pop      = (state == RMW_IDLE) && !empty;
  assign rmw_idle = (state == RMW_IDLE);
  assign rd_done  = (state == RMW_WAIT_RD) && (vram_rd_req == vram_rd_ack);
  assign wr_done  = (state == RMW_WAIT_WR) && (vram_wr_req == vram_wr_ack);
  assign rd_byte  = vram_rd_data;  // Valid in the rd_done cycle

  always_comb begin
    // Pick destination pixel
    if (mode_graphic_7) begin
      dst_pix = rd_byte.pix8;
    end else if (x_lo_q) begin
      dst_pix = {4'h0, rd_byte.nib.pix_lo};
    end else begin
      dst_pix = {4'h0, rd_byte.nib.pix_hi};
    end
    case (lop_q)
      LOP_IMP: lop_res = clr_q;
      LOP_AND: lop_res = clr_q & dst_pix;
      LOP_OR:  lop_res = clr_q | dst_pix;
      LOP_XOR: lop_res = clr_q ^ dst_pix;
      LOP_NOT: lop_res = ~clr_q;
      default: lop_res = dst_pix;  // Keep destination
    endcase
    // Merge back leaving the neighbour nibble untouched
    merged = rd_byte;
    if (mode_graphic_7) begin
      merged.pix8 = lop_res;
    end else if (x_lo_q) begin
      merged.nib.pix_lo = lop_res[3:0];
    end else begin
      merged.nib.pix_hi = lop_res[3:0];
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state       <= RMW_IDLE;
      vram_rd_req <= 1'b0;
      vram_wr_req <= 1'b0;
    end else begin
      case (state)
        RMW_IDLE: begin
          if (!empty) begin
            if (in_byte) begin
              vram_wr_req <= ~vram_wr_req;  // Straight byte write
              state       <= RMW_WAIT_WR;
            end else if (!in_skip) begin
              vram_rd_req <= ~vram_rd_req;
              state       <= RMW_WAIT_RD;
            end
            // Skipped items are just dropped from the FIFO
          end
        end
        RMW_WAIT_RD: begin
          if (rd_done) begin
            vram_wr_req <= ~vram_wr_req;
            state       <= RMW_WAIT_WR;
          end
        end
        RMW_WAIT_WR: begin
          if (wr_done) begin
            state <= RMW_IDLE;
          end
        end
        default: state <= RMW_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      vram_addr    <= pop_data[PIXOP_ADDR_LSB +: VRAM_ADDR_W];
      x_lo_q       <= pop_data[PIXOP_XLO_BIT];
      clr_q        <= in_clr.pix8;
      lop_q        <= pop_data[PIXOP_LOP_LSB +: 3];
      vram_wr_data <= in_clr.pix8;  // Final data for byte items
    end else if (rd_done) begin
      vram_wr_data <= merged.pix8;
    end
  end

endmodule

`default_nettype wire

// ==== tb/tb_vdp_command.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_vdp_command;
  import vdp_cmd_pkg::*;

  localparam int VRAM_SIZE = 1 << VRAM_ADDR_W;

  logic                   clk;
  logic                   reset;
  logic                   mode_graphic_7;
  logic                   reg_wr_req;
  logic [REG_NUM_W-1:0]   reg_num;
  logic [7:0]             reg_data;
  logic                   reg_wr_ack;
  logic                   vram_rd_ack = 1'b0;
  logic                   vram_wr_ack = 1'b0;
  logic [7:0]             vram_rd_data = 8'h00;
  logic                   vram_rd_req;
  logic                   vram_wr_req;
  logic [VRAM_ADDR_W-1:0] vram_addr;
  logic [7:0]             vram_wr_data;
  logic                   ce;

  logic [7:0] vram [VRAM_SIZE];
  logic       fill_req;            // Restore the address pattern
  int         rd_count;
  int         wr_count;
  int         rd_wait = 0;
  int         wr_wait = 0;
  int         cycle_count = 0;
  int         cycle_limit = 0;     // Zero until the file is read
  string      cur_name = "setup";
  string      lines [$];

  vdp_command #(.FIFO_DEPTH(4)) dut (
    .clk, .reset, .mode_graphic_7, .reg_wr_req, .reg_num, .reg_data, .reg_wr_ack,
    .vram_rd_ack, .vram_wr_ack, .vram_rd_data, .vram_rd_req, .vram_wr_req,
    .vram_addr, .vram_wr_data, .ce
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns
  end

  // VRAM model whose bytes start as addr[7:0] ^ addr[15:8] with bit 16 in the MSB
  always @(posedge clk) begin
    if (reset || fill_req) begin
      for (int a = 0; a < VRAM_SIZE; a++) begin
        vram[a] = a[7:0] ^ a[15:8] ^ {a[16], 7'h00};
      end
      rd_count <= 0;
      wr_count <= 0;
      if (reset) begin
        vram_rd_ack <= 1'b0;
        vram_wr_ack <= 1'b0;
      end
    end else begin
      if (vram_rd_req != vram_rd_ack) begin
        if (rd_wait == 0) begin
          vram_rd_data <= vram[vram_addr];
          vram_rd_ack  <= vram_rd_req;   // Data valid with the ack
          rd_count     <= rd_count + 1;
          rd_wait      <= $urandom % 4;  // Delay of the next read
        end else begin
          rd_wait <= rd_wait - 1;
        end
      end
      if (vram_wr_req != vram_wr_ack) begin
        if (wr_wait == 0) begin
          vram[vram_addr] = vram_wr_data;
          vram_wr_ack <= vram_wr_req;
          wr_count    <= wr_count + 1;
          wr_wait     <= $urandom % 4;
        end else begin
          wr_wait <= wr_wait - 1;
        end
      end
    end
  end

  // Run limit
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit != 0 && cycle_count > cycle_limit) begin
      $display("Timeout: the tests did not finish within %0d clock cycles", cycle_limit);
      $display("Result: FAILED");
      $fatal(1, "timeout");
    end
  end

  task automatic check_value(input string what, input int expected, input int actual);
    if (expected != actual) begin
      $display("[ERROR] %0s: expected 0x%0h, actual 0x%0h", what, expected, actual);
      $display("Result: FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic bad_line(input string line);
    $display("Test file line could not be parsed: %0s", line);
    $display("Result: FAILED");
    $fatal(1, "bad test file");
  endtask

  task automatic start_test(input logic g7);
    @(posedge clk);
    mode_graphic_7 <= g7;
    fill_req       <= 1'b1;  // Model refills on the next edge
    @(posedge clk);
    fill_req <= 1'b0;
    @(negedge clk);
  endtask

  // Ack is due one cycle after the request toggle
  task automatic write_reg(input logic [REG_NUM_W-1:0] num, input logic [7:0] data);
    int acc_before;
    acc_before = rd_count + wr_count;
    @(posedge clk);
    reg_num    <= num;
    reg_data   <= data;
    reg_wr_req <= ~reg_wr_req;
    @(negedge clk);
    @(negedge clk);
    check_value({cur_name, " register ack"}, reg_wr_req, reg_wr_ack);
    if (num == REG_CMR) begin
      check_value({cur_name, " ce after R46"}, 1, ce);
    end else begin
      check_value({cur_name, " ce during setup"}, 0, ce);
      check_value({cur_name, " VRAM accesses during setup"}, acc_before, rd_count + wr_count);
    end
  endtask

  // R36..R46 in order, then wait for CE to drop
  task automatic run_command(input int writes, input logic [7:0] regs [11]);
    int wr_before;
    wr_before = wr_count;
    for (int k = 0; k < 11; k++) begin
      write_reg(REG_DX_L + 4'(k), regs[k]);
    end
    while (ce) @(negedge clk);
    check_value({cur_name, " VRAM write count"}, writes, wr_count - wr_before);
    check_value({cur_name, " write ack at ce fall"}, vram_wr_req, vram_wr_ack);
    check_value({cur_name, " read ack at ce fall"}, vram_rd_req, vram_rd_ack);
  endtask

  initial begin
    int              fd;
    int              n;
    int              mode;
    int              cnt;
    int              addr;
    int              data;
    logic [8*32-1:0] name_v;
    logic [7:0]      v [11];
    string           line;

    reset          = 1'b1;
    mode_graphic_7 = 1'b0;
    reg_wr_req     = 1'b0;
    reg_num        = '0;
    reg_data       = 8'h00;
    fill_req       = 1'b0;
    void'($urandom(32'h284e49e3));

    fd = $fopen("tb/vdp_cmd_tests.txt", "r");
    if (fd == 0) begin
      $display("Could not open the test file tb/vdp_cmd_tests.txt");
      $display("Result: FAILED");
      $fatal(1, "no test file");
    end
    // Base margin, then per test, per command and per expected write
    cycle_limit = 100;
    while ($fgets(line, fd) != 0) begin
      if (line.getc(0) == "T") begin
        cycle_limit += 10;
        lines.push_back(line);
      end else if (line.getc(0) == "W") begin
        if ($sscanf(line, "W %d", cnt) != 1) bad_line(line);
        cycle_limit += 60 + 40 * cnt;
        lines.push_back(line);
      end else if (line.getc(0) == "E") begin
        lines.push_back(line);
      end
    end
    $fclose(fd);

    repeat (4) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);

    foreach (lines[i]) begin
      line = lines[i];
      if (line.getc(0) == "T") begin
        n = $sscanf(line, "T %s %d", name_v, mode);
        if (n != 2) bad_line(line);
        cur_name = $sformatf("%0s", name_v);
        start_test(mode != 0);
      end else if (line.getc(0) == "W") begin
        n = $sscanf(line, "W %d %h %h %h %h %h %h %h %h %h %h %h", cnt,
                    v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10]);
        if (n != 12) bad_line(line);
        run_command(cnt, v);
      end else begin
        n = $sscanf(line, "E %h %h", addr, data);
        if (n != 2) bad_line(line);
        check_value($sformatf("%0s byte %05h", cur_name, addr), data, vram[addr]);
      end
    end
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/vdp_cmd_tests.txt ====
# T name mode (1 graphic 7, 0 graphic 4) | E addr byte, expected VRAM byte in hex
# W writes: VRAM write count (decimal), then R36..R46 hex: dxl dxh dyl dyh nxl nxh nyl nyh clr arg cmr
T hmmv_g4_clip 0
W 3 fa 00 20 00 14 00 01 00 3c 00 c0
E 107d 3c
E 107f 3c
E 107c 6c
E 1080 90
T lmmv_g4_ops 0
W 1 02 00 40 00 01 00 01 00 07 00 80
W 1 05 00 40 00 01 00 01 00 0d 00 81
W 1 06 00 40 00 01 00 01 00 f8 00 82
W 1 09 00 40 00 01 00 01 00 0c 00 83
W 1 0a 00 40 00 01 00 01 00 03 00 84
E 2001 71
E 2002 20
E 2003 a3
E 2004 28
E 2005 c5
T lmmv_g4_transparent 0
W 0 20 00 50 00 02 00 01 00 f0 00 88
W 2 22 00 50 00 02 00 01 00 05 00 88
E 2810 38
E 2811 55
T pset_g7_dix_diy 1
W 1 80 00 30 00 05 00 05 00 99 0c 50
E 3080 99
E 307f 4f
E 3081 b1
T hmmv_g7_backpressure 1
W 15 10 00 02 00 05 00 08 00 e7 0c c0
E 0210 e7
E 000c e7
E 0211 13
E 000b 0b

// ==== verilog.f ====
hdl/vdp_cmd_pkg.sv
hdl/vdp_cmd_regs.sv
hdl/vdp_rect_walker.sv
hdl/vdp_pixel_fifo.sv
hdl/vdp_vram_rmw.sv
hdl/vdp_command.sv
tb/tb_vdp_command.sv
